/* verilog/fetch_consts.svh */
`ifndef FETCH_CONSTS_SVH
`define FETCH_CONSTS_SVH

// pc after reset, start of the boot image
`define FETCH_RESET_PC 64'h0000_0000_8000_0000

// address and data path width
`define FETCH_XLEN 64

// one uncompressed instruction
`define FETCH_ILEN 32

// addi x0, x0, 0
`define FETCH_NOP 32'h0000_0013

// AR/R transaction id width
`define FETCH_ID_W 4

// R channel response code width
`define FETCH_RESP_W 2

// sequential fetch step in bytes
`define FETCH_PC_STEP 64'd4

`endif

/* verilog/fetch_pkg.sv */
`include "fetch_consts.svh"

package fetch_pkg;

  // byte address on the bus and in the pc
  typedef logic [`FETCH_XLEN-1:0] addr_t;

  // one 64-bit read beat
  typedef logic [`FETCH_XLEN-1:0] xdata_t;

  // one 32-bit instruction
  typedef logic [`FETCH_ILEN-1:0] inst_t;

  // owner of a read, carried on ar_id and back through the router
  typedef enum logic [`FETCH_ID_W-1:0] {
    ID_FETCH = 1,
    ID_DATA  = 2
  } bus_id_t;

  // read master states
  typedef enum logic [1:0] {
    RD_IDLE,
    RD_ADDR,
    RD_DATA
  } rd_state_t;

  // arbiter states
  typedef enum logic [1:0] {
    ARB_IDLE,
    ARB_BUSY,
    ARB_ACK
  } arb_state_t;

endpackage

/* verilog/pc_gen.sv */
`timescale 1ns/1ps
`include "fetch_consts.svh"

module pc_gen import fetch_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  stall_i,
  input  logic  redirect_valid_i,
  input  addr_t redirect_pc_i,
  input  logic  fetch_done_i,
  input  logic  fetch_grant_i,
  output logic  fetch_req_o,
  output addr_t fetch_pc_o,
  output logic  redirect_pulse_o
);

  // current fetch address
  addr_t pc_q;
  // a granted fetch has not returned yet
  logic  pending_q;
  // redirect seen since the outstanding fetch was issued
  logic  stale_q;

  // only one fetch in flight, decode stall blocks new ones
  assign fetch_req_o = !pending_q && !stall_i;
  assign fetch_pc_o  = pc_q;

  // redirect hits a fetch that is in flight or granted right now
  // a fetch already returning this cycle is delivered as is
  assign redirect_pulse_o = redirect_valid_i &&
                            ((pending_q && !fetch_done_i) || fetch_grant_i);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pending_q <= 1'b0;
    end else if (fetch_grant_i) begin
      pending_q <= 1'b1;
    end else if (fetch_done_i) begin
      pending_q <= 1'b0;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      stale_q <= 1'b0;
    end else if (redirect_pulse_o) begin
      stale_q <= 1'b1;
    end else if (fetch_done_i) begin
      stale_q <= 1'b0;
    end
  end

  // redirect wins over the sequential step
  // after a squashed fetch the target stays in place
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc_q <= `FETCH_RESET_PC;
    end else if (redirect_valid_i) begin
      pc_q <= redirect_pc_i;
    end else if (fetch_done_i && !stale_q) begin
      pc_q <= pc_q + `FETCH_PC_STEP;
    end
  end

endmodule

/* verilog/req_arbiter.sv */
`timescale 1ns/1ps

module req_arbiter import fetch_pkg::*; (
  input  logic    clk,
  input  logic    rst_n,
  input  logic    fetch_req_i,
  input  addr_t   fetch_pc_i,
  input  logic    mem_req_i,
  input  addr_t   mem_addr_i,
  input  logic    rd_accept_i,
  input  logic    fetch_done_i,
  input  logic    data_done_i,
  output logic    fetch_grant_o,
  output logic    rd_valid_o,
  output addr_t   rd_addr_o,
  output bus_id_t rd_id_o,
  output logic    mem_ack_o
);

  arb_state_t state_q;
  // who owns the bus until its done returns
  bus_id_t    owner_q;
  addr_t      addr_q;
  logic       rd_valid_q;

  logic       pick_data;
  logic       pick_fetch;

  // data read has priority over fetch
  assign pick_data  = (state_q == ARB_IDLE) && mem_req_i;
  assign pick_fetch = (state_q == ARB_IDLE) && !mem_req_i && fetch_req_i;

  assign fetch_grant_o = pick_fetch;
  assign rd_valid_o    = rd_valid_q;
  assign rd_addr_o     = addr_q;
  assign rd_id_o       = owner_q;

  // ack rises with the registered read data and holds
  // until the memory stage drops its request
  assign mem_ack_o = (state_q == ARB_ACK) ||
                     ((state_q == ARB_BUSY) && (owner_q == ID_DATA) && data_done_i);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= ARB_IDLE;
      owner_q <= ID_FETCH;
    end else begin
      case (state_q)
        ARB_IDLE: begin
          if (pick_data) begin
            owner_q <= ID_DATA;
            state_q <= ARB_BUSY;
          end else if (pick_fetch) begin
            owner_q <= ID_FETCH;
            state_q <= ARB_BUSY;
          end
        end
        ARB_BUSY: begin
          // wait for the router to hand back our own beat
          if (owner_q == ID_FETCH && fetch_done_i) begin
            state_q <= ARB_IDLE;
          end else if (owner_q == ID_DATA && data_done_i) begin
            state_q <= ARB_ACK;
          end
        end
        ARB_ACK: begin
          // four-phase return to zero
          if (!mem_req_i) begin
            state_q <= ARB_IDLE;
          end
        end
        default: state_q <= ARB_IDLE;
      endcase
    end
  end

  // held toward the master until it takes the request
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_valid_q <= 1'b0;
    end else if (pick_data || pick_fetch) begin
      rd_valid_q <= 1'b1;
    end else if (rd_accept_i) begin
      rd_valid_q <= 1'b0;
    end
  end

  // request address captured at grant
  always_ff @(posedge clk) begin
    if (pick_data) begin
      addr_q <= mem_addr_i;
    end else if (pick_fetch) begin
      addr_q <= fetch_pc_i;
    end
  end

endmodule

/* verilog/axi_rd_master.sv */
`timescale 1ns/1ps
`include "fetch_consts.svh"

module axi_rd_master import fetch_pkg::*; (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     rd_valid_i,
  input  addr_t                    rd_addr_i,
  input  bus_id_t                  rd_id_i,
  input  logic                     ar_ready_i,
  input  logic                     r_valid_i,
  input  xdata_t                   r_data_i,
  input  logic [`FETCH_RESP_W-1:0] r_resp_i,
  output logic                     rd_accept_o,
  output logic                     ar_valid_o,
  output addr_t                    ar_addr_o,
  output bus_id_t                  ar_id_o,
  output logic                     r_ready_o,
  output logic                     rd_done_o,
  output xdata_t                   rd_data_o,
  output bus_id_t                  rd_resp_id_o
);

  rd_state_t state_q;
  addr_t     addr_q;
  bus_id_t   id_q;
  logic      accept_q;

  logic      take_req;
  logic      r_err;

  assign take_req = (state_q == RD_IDLE) && rd_valid_i;

  // slverr or decerr
  assign r_err = r_resp_i[1];

  // AR stays up with stable payload until ready is seen
  assign ar_valid_o = (state_q == RD_ADDR);
  assign ar_addr_o  = addr_q;
  assign ar_id_o    = id_q;
  assign r_ready_o  = (state_q == RD_DATA);

  assign rd_accept_o = accept_q;

  // beat handshake, passed on for one cycle
  assign rd_done_o    = r_ready_o && r_valid_i;
  assign rd_data_o    = r_err ? '0 : r_data_i;
  assign rd_resp_id_o = id_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= RD_IDLE;
    end else begin
      case (state_q)
        RD_IDLE: if (take_req) state_q <= RD_ADDR;
        RD_ADDR: if (ar_ready_i) state_q <= RD_DATA;
        RD_DATA: if (r_valid_i) state_q <= RD_IDLE;
        default: state_q <= RD_IDLE;
      endcase
    end
  end

  // one-cycle accept back to the arbiter
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      accept_q <= 1'b0;
    end else begin
      accept_q <= take_req;
    end
  end

  // latch request, bus reads are 8-byte aligned
  always_ff @(posedge clk) begin
    if (take_req) begin
      addr_q <= {rd_addr_i[`FETCH_XLEN-1:3], 3'b000};
      id_q   <= rd_id_i;
    end
  end

endmodule

/* verilog/resp_router.sv */
`timescale 1ns/1ps
`include "fetch_consts.svh"

module resp_router import fetch_pkg::*; (
  input  logic    clk,
  input  logic    rst_n,
  input  logic    rd_done_i,
  input  xdata_t  rd_data_i,
  input  bus_id_t rd_resp_id_i,
  input  addr_t   fetch_pc_i,
  input  logic    fetch_grant_i,
  input  logic    redirect_pulse_i,
  output logic    fetch_done_o,
  output logic    data_done_o,
  output logic    inst_valid_o,
  output inst_t   inst_o,
  output addr_t   inst_pc_o,
  output xdata_t  mem_rdata_o
);

  // pc of the fetch in flight
  addr_t  pc_q;
  // squash flag for the fetch in flight
  logic   stale_q;
  logic   inst_valid_q;
  logic   data_done_q;
  inst_t  inst_q;
  addr_t  inst_pc_q;
  xdata_t mem_rdata_q;

  logic   fetch_hit;
  logic   data_hit;
  inst_t  inst_sel;

  assign fetch_hit = rd_done_i && (rd_resp_id_i == ID_FETCH);
  assign data_hit  = rd_done_i && (rd_resp_id_i == ID_DATA);

  // upper word for pc[2] set, late redirect turns it into a nop
  assign inst_sel = (stale_q || redirect_pulse_i) ? `FETCH_NOP :
                    pc_q[2] ? rd_data_i[63:32] : rd_data_i[31:0];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      stale_q <= 1'b0;
    end else if (fetch_grant_i) begin
      // redirect may land in the grant cycle itself
      stale_q <= redirect_pulse_i;
    end else if (redirect_pulse_i) begin
      stale_q <= 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      inst_valid_q <= 1'b0;
      data_done_q  <= 1'b0;
    end else begin
      inst_valid_q <= fetch_hit;
      data_done_q  <= data_hit;
    end
  end

  always_ff @(posedge clk) begin
    if (fetch_grant_i) begin
      pc_q <= fetch_pc_i;
    end
    if (fetch_hit) begin
      inst_q    <= inst_sel;
      inst_pc_q <= pc_q;
    end
    if (data_hit) begin
      mem_rdata_q <= rd_data_i;
    end
  end

  // the registered pulse also retires the fetch in pc_gen
  assign fetch_done_o = inst_valid_q;
  assign data_done_o  = data_done_q;
  assign inst_valid_o = inst_valid_q;
  assign inst_o       = inst_q;
  assign inst_pc_o    = inst_pc_q;
  assign mem_rdata_o  = mem_rdata_q;

endmodule

/* verilog/fetch_unit_top.sv */
`timescale 1ns/1ps
`include "fetch_consts.svh"

module fetch_unit_top import fetch_pkg::*; (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     stall_i,
  input  logic                     redirect_valid_i,
  input  addr_t                    redirect_pc_i,
  input  logic                     mem_req_i,
  input  addr_t                    mem_addr_i,
  input  logic                     ar_ready_i,
  input  logic                     r_valid_i,
  input  xdata_t                   r_data_i,
  input  logic [`FETCH_RESP_W-1:0] r_resp_i,
  output logic                     inst_valid_o,
  output inst_t                    inst_o,
  output addr_t                    inst_pc_o,
  output logic                     mem_ack_o,
  output xdata_t                   mem_rdata_o,
  output logic                     ar_valid_o,
  output addr_t                    ar_addr_o,
  output bus_id_t                  ar_id_o,
  output logic                     r_ready_o
);

  // pc_gen to arbiter and router
  logic    fetch_req;
  addr_t   fetch_pc;
  logic    fetch_grant;
  logic    redirect_pulse;

  // arbiter to read master
  logic    rd_valid;
  addr_t   rd_addr;
  bus_id_t rd_id;
  logic    rd_accept;

  // read master to router
  logic    rd_done;
  xdata_t  rd_data;
  bus_id_t rd_resp_id;

  // router back to the requesters
  logic    fetch_done;
  logic    data_done;

  pc_gen u_pc_gen (
    .clk              (clk),
    .rst_n            (rst_n),
    .stall_i          (stall_i),
    .redirect_valid_i (redirect_valid_i),
    .redirect_pc_i    (redirect_pc_i),
    .fetch_done_i     (fetch_done),
    .fetch_grant_i    (fetch_grant),
    .fetch_req_o      (fetch_req),
    .fetch_pc_o       (fetch_pc),
    .redirect_pulse_o (redirect_pulse)
  );

  req_arbiter u_req_arbiter (
    .clk           (clk),
    .rst_n         (rst_n),
    .fetch_req_i   (fetch_req),
    .fetch_pc_i    (fetch_pc),
    .mem_req_i     (mem_req_i),
    .mem_addr_i    (mem_addr_i),
    .rd_accept_i   (rd_accept),
    .fetch_done_i  (fetch_done),
    .data_done_i   (data_done),
    .fetch_grant_o (fetch_grant),
    .rd_valid_o    (rd_valid),
    .rd_addr_o     (rd_addr),
    .rd_id_o       (rd_id),
    .mem_ack_o     (mem_ack_o)
  );

  axi_rd_master u_axi_rd_master (
    .clk          (clk),
    .rst_n        (rst_n),
    .rd_valid_i   (rd_valid),
    .rd_addr_i    (rd_addr),
    .rd_id_i      (rd_id),
    .ar_ready_i   (ar_ready_i),
    .r_valid_i    (r_valid_i),
    .r_data_i     (r_data_i),
    .r_resp_i     (r_resp_i),
    .rd_accept_o  (rd_accept),
    .ar_valid_o   (ar_valid_o),
    .ar_addr_o    (ar_addr_o),
    .ar_id_o      (ar_id_o),
    .r_ready_o    (r_ready_o),
    .rd_done_o    (rd_done),
    .rd_data_o    (rd_data),
    .rd_resp_id_o (rd_resp_id)
  );

  resp_router u_resp_router (
    .clk              (clk),
    .rst_n            (rst_n),
    .rd_done_i        (rd_done),
    .rd_data_i        (rd_data),
    .rd_resp_id_i     (rd_resp_id),
    .fetch_pc_i       (fetch_pc),
    .fetch_grant_i    (fetch_grant),
    .redirect_pulse_i (redirect_pulse),
    .fetch_done_o     (fetch_done),
    .data_done_o      (data_done),
    .inst_valid_o     (inst_valid_o),
    .inst_o           (inst_o),
    .inst_pc_o        (inst_pc_o),
    .mem_rdata_o      (mem_rdata_o)
  );

endmodule

/* verif/tb_clk_gen.sv */
`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk_o,
  output logic rst_n_o
);

  // 40 ns period
  initial begin
    clk_o = 1'b0;
    forever begin
      #20 clk_o = ~clk_o;
    end
  end

  // reset held over the first two rising edges
  initial begin
    rst_n_o = 1'b0;
    repeat (2) @(posedge clk_o);
    #1 rst_n_o = 1'b1;
  end

endmodule

/* verif/tb_axi_mem.sv */
`timescale 1ns/1ps
`include "fetch_consts.svh"

module tb_axi_mem import fetch_pkg::*; (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     ar_valid_i,
  input  addr_t                    ar_addr_i,
  input  logic                     r_ready_i,
  output logic                     ar_ready_o,
  output logic                     r_valid_o,
  output xdata_t                   r_data_o,
  output logic [`FETCH_RESP_W-1:0] r_resp_o
);

  localparam int MEM_WORDS = 16;

  // image written by the testbench top at time zero
  xdata_t      mem [0:MEM_WORDS-1];
  logic [31:0] rng;
  logic [1:0]  ar_wait;
  logic [1:0]  r_wait;
  // address taken, beat not yet offered
  logic        r_pend;
  addr_t       r_addr;
  // edge samples
  logic        ar_hs;
  logic        r_hs;
  addr_t       ar_addr_s;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // next wait, 0 to 3 cycles
  task automatic draw_wait(output logic [1:0] w);
    rng = xorshift32(rng);
    w = rng[1:0];
  endtask

  initial begin
    rng        = 32'ha3083f07;
    ar_ready_o = 1'b0;
    r_valid_o  = 1'b0;
    r_data_o   = '0;
    r_resp_o   = '0;
    r_pend     = 1'b0;
    r_addr     = '0;
    r_wait     = 2'd0;
    draw_wait(ar_wait);
  end

  always begin
    @(posedge clk);
    // handshakes as the DUT sees them on this edge
    ar_hs     = ar_valid_i && ar_ready_o;
    r_hs      = r_valid_o && r_ready_i;
    ar_addr_s = ar_addr_i;
    #1;
    if (!rst_n) begin
      ar_ready_o = 1'b0;
      r_valid_o  = 1'b0;
      r_pend     = 1'b0;
    end else begin
      if (r_hs) begin
        r_valid_o = 1'b0;
      end
      if (ar_hs) begin
        ar_ready_o = 1'b0;
        r_pend     = 1'b1;
        r_addr     = ar_addr_s;
        draw_wait(r_wait);
        draw_wait(ar_wait);
      end else if (ar_valid_i && !ar_ready_o) begin
        // count down before taking the address
        if (ar_wait == 2'd0) begin
          ar_ready_o = 1'b1;
        end else begin
          ar_wait = ar_wait - 2'd1;
        end
      end
      if (r_pend && !r_valid_o) begin
        if (r_wait == 2'd0) begin
          r_valid_o = 1'b1;
          r_data_o  = mem[(r_addr >> 3) % MEM_WORDS];
          r_pend    = 1'b0;
        end else begin
          r_wait = r_wait - 2'd1;
        end
      end
    end
  end

endmodule

/* verif/tb_fetch_unit.sv */
`timescale 1ns/1ps
`include "fetch_consts.svh"

module tb_fetch_unit import fetch_pkg::*; ();

  localparam int MEM_WORDS = 16;
  localparam int TD_WORDS  = 48;
  // command lines start after the image
  localparam int CMD_BASE  = 16;

  logic                     clk;
  logic                     rst_n;
  logic                     stall;
  logic                     redirect_valid;
  addr_t                    redirect_pc;
  logic                     mem_req;
  addr_t                    mem_addr;
  logic                     ar_ready;
  logic                     r_valid;
  xdata_t                   r_data;
  logic [`FETCH_RESP_W-1:0] r_resp;
  logic                     inst_valid;
  inst_t                    inst;
  addr_t                    inst_pc;
  logic                     mem_ack;
  xdata_t                   mem_rdata;
  logic                     ar_valid;
  addr_t                    ar_addr;
  bus_id_t                  ar_id;
  logic                     r_ready;

  logic [63:0] tdata [0:TD_WORDS-1];
  int          n_cmds;
  int          cycles;
  int          cycle_limit;
  int          n_inst;
  int          err_inst;
  int          err_addr;
  int          err_data;
  int          err_id;
  int          err_proto;
  // reference pc of the next fetch to come out
  addr_t       exp_pc;
  addr_t       redirect_target;
  // the fetch in flight was hit by a redirect
  logic        squash_next;
  logic        ar_wait_prev;
  addr_t       ar_addr_prev;
  // data read requested but not yet seen on AR
  logic        data_ar_due;
  addr_t       data_ar_addr;
  // owner of the last AR taken
  logic        ar_fetch;
  // R beat on the previous edge and its owner
  logic        beat_prev;
  logic        beat_fetch_prev;

  tb_clk_gen clk_gen0 (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  tb_axi_mem mem0 (
    .clk        (clk),
    .rst_n      (rst_n),
    .ar_valid_i (ar_valid),
    .ar_addr_i  (ar_addr),
    .r_ready_i  (r_ready),
    .ar_ready_o (ar_ready),
    .r_valid_o  (r_valid),
    .r_data_o   (r_data),
    .r_resp_o   (r_resp)
  );

  fetch_unit_top dut0 (
    .clk              (clk),
    .rst_n            (rst_n),
    .stall_i          (stall),
    .redirect_valid_i (redirect_valid),
    .redirect_pc_i    (redirect_pc),
    .mem_req_i        (mem_req),
    .mem_addr_i       (mem_addr),
    .ar_ready_i       (ar_ready),
    .r_valid_i        (r_valid),
    .r_data_i         (r_data),
    .r_resp_i         (r_resp),
    .inst_valid_o     (inst_valid),
    .inst_o           (inst),
    .inst_pc_o        (inst_pc),
    .mem_ack_o        (mem_ack),
    .mem_rdata_o      (mem_rdata),
    .ar_valid_o       (ar_valid),
    .ar_addr_o        (ar_addr),
    .ar_id_o          (ar_id),
    .r_ready_o        (r_ready)
  );

  task automatic check_inst(input string name, input inst_t exp, input inst_t act);
    if (act !== exp) begin
      $display("Error %s: expected %h, got %h", name, exp, act);
      err_inst++;
    end
  endtask

  task automatic check_addr(input string name, input addr_t exp, input addr_t act);
    if (act !== exp) begin
      $display("Error %s: expected %h, got %h", name, exp, act);
      err_addr++;
    end
  endtask

  task automatic check_xdata(input string name, input xdata_t exp, input xdata_t act);
    if (act !== exp) begin
      $display("Error %s: expected %h, got %h", name, exp, act);
      err_data++;
    end
  endtask

  task automatic check_id(input string name, input bus_id_t exp, input bus_id_t act);
    if (act !== exp) begin
      $display("Error %s: expected %h, got %h", name, exp, act);
      err_id++;
    end
  endtask

  // half of the 8-byte word picked by pc bit 2
  function automatic inst_t expect_inst(input addr_t pc);
    logic [63:0] word;
    word = tdata[(pc >> 3) % MEM_WORDS];
    if (pc[2]) begin
      return word[63:32];
    end
    return word[31:0];
  endfunction

  task automatic print_error_counts();
    $display("error counts: inst %0d, addr %0d, data %0d, id %0d, protocol %0d",
             err_inst, err_addr, err_data, err_id, err_proto);
  endtask

  // inputs change 1 ns after the edge
  task automatic wait_edge();
    @(posedge clk);
    #1;
  endtask

  task automatic run_insts(input int n);
    int target;
    target = n_inst + n;
    wait (n_inst >= target);
    wait_edge();
  endtask

  task automatic redirect_to(input addr_t target);
    // a fetch on AR is surely in flight and has to come back squashed
    @(posedge clk);
    while (!(ar_valid && ar_id == ID_FETCH)) begin
      @(posedge clk);
    end
    #1;
    redirect_target = target;
    squash_next     = 1'b1;
    redirect_pc     = target;
    redirect_valid  = 1'b1;
    wait_edge();
    redirect_valid = 1'b0;
  endtask

  task automatic stall_for(input int n);
    int start;
    stall = 1'b1;
    start = n_inst;
    repeat (n) wait_edge();
    // only the fetch already in flight may finish
    if (n_inst - start > 1) begin
      $display("%0d instructions came out during a stall of %0d cycles",
               n_inst - start, n);
      err_proto++;
    end
    stall = 1'b0;
  endtask

  task automatic read_data_word(input addr_t addr);
    xdata_t exp;
    exp          = tdata[(addr >> 3) % MEM_WORDS];
    data_ar_addr = {addr[63:3], 3'b000};
    data_ar_due  = 1'b1;
    mem_addr     = addr;
    mem_req      = 1'b1;
    @(posedge clk);
    while (!mem_ack) begin
      @(posedge clk);
    end
    check_xdata("mem_rdata_o", exp, mem_rdata);
    if (data_ar_due) begin
      $display("the data read never went out on AR at its aligned address");
      err_proto++;
      data_ar_due = 1'b0;
    end
    // req still up so ack has to stay
    @(posedge clk);
    if (!mem_ack) begin
      $display("mem_ack_o fell while mem_req_i was still high");
      err_proto++;
    end
    #1;
    mem_req = 1'b0;
    @(posedge clk);
    while (mem_ack) begin
      @(posedge clk);
    end
    #1;
  endtask

  // instruction stream and AR channel checked on each edge
  always @(posedge clk) begin
    if (rst_n) begin
      // router output is registered one cycle behind the R beat
      if (inst_valid !== (beat_prev && beat_fetch_prev)) begin
        $display("inst_valid_o is not exactly one cycle after a fetch beat");
        err_proto++;
      end
      if (beat_prev && !beat_fetch_prev && !mem_ack) begin
        $display("mem_ack_o did not rise one cycle after the data beat");
        err_proto++;
      end
      if (inst_valid) begin
        check_addr("inst_pc_o", exp_pc, inst_pc);
        if (squash_next) begin
          check_inst("inst_o", `FETCH_NOP, inst);
          exp_pc      = redirect_target;
          squash_next = 1'b0;
        end else begin
          check_inst("inst_o", expect_inst(exp_pc), inst);
          exp_pc = exp_pc + 64'd4;
        end
        n_inst++;
      end
      // every AR other than the pending data read fetches exp_pc
      if (ar_valid && ar_ready) begin
        if (data_ar_due && ar_addr == data_ar_addr) begin
          check_id("ar_id_o", ID_DATA, ar_id);
          data_ar_due = 1'b0;
          ar_fetch    = 1'b0;
        end else begin
          check_id("ar_id_o", ID_FETCH, ar_id);
          check_addr("ar_addr_o", {exp_pc[63:3], 3'b000}, ar_addr);
          ar_fetch = 1'b1;
        end
      end
      if (ar_wait_prev) begin
        if (!ar_valid) begin
          $display("ar_valid_o dropped before ar_ready_i was seen");
          err_proto++;
        end else begin
          check_addr("ar_addr_o", ar_addr_prev, ar_addr);
        end
      end
      ar_wait_prev    = ar_valid && !ar_ready;
      ar_addr_prev    = ar_addr;
      beat_prev       = r_valid && r_ready;
      beat_fetch_prev = ar_fetch;
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > cycle_limit) begin
      $display("timeout after %0d cycles, the command sequence did not finish", cycles);
      print_error_counts();
      $display("TESTS FAILED");
      $finish;
    end
  end

  initial begin
    logic [63:0] cmd;
    logic [3:0]  op;
    stall           = 1'b0;
    redirect_valid  = 1'b0;
    redirect_pc     = '0;
    mem_req         = 1'b0;
    mem_addr        = '0;
    squash_next     = 1'b0;
    redirect_target = '0;
    exp_pc          = `FETCH_RESET_PC;
    ar_wait_prev    = 1'b0;
    ar_addr_prev    = '0;
    data_ar_due     = 1'b0;
    data_ar_addr    = '0;
    ar_fetch        = 1'b0;
    beat_prev       = 1'b0;
    beat_fetch_prev = 1'b0;
    n_inst          = 0;
    cycles          = 0;
    err_inst        = 0;
    err_addr        = 0;
    err_data        = 0;
    err_id          = 0;
    err_proto       = 0;
    $readmemh("verif/fetch_testdata.txt", tdata);
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem0.mem[i] = tdata[i];
    end
    // command list ends at opcode 0 or at the first unwritten entry
    n_cmds = 0;
    while ((CMD_BASE + n_cmds < TD_WORDS) && (tdata[CMD_BASE + n_cmds][63:60] != 4'h0)) begin
      n_cmds++;
    end
    cycle_limit = 40 * n_cmds + 100;

    // reset has reached every register by now
    @(posedge clk);
    #1;
    if ({inst_valid, ar_valid, r_ready, mem_ack} !== 4'b0000) begin
      $display("outputs are not idle during reset");
      err_proto++;
    end
    wait (rst_n);
    wait_edge();

    for (int i = 0; i < n_cmds; i++) begin
      cmd = tdata[CMD_BASE + i];
      op  = cmd[63:60];
      case (op)
        4'h1: run_insts(int'(cmd[31:0]));
        4'h2: redirect_to({4'h0, cmd[59:0]});
        4'h3: stall_for(int'(cmd[31:0]));
        4'h4: read_data_word({4'h0, cmd[59:0]});
        default: begin
          $display("unknown command %h in the test data", cmd);
          err_proto++;
        end
      endcase
    end

    print_error_counts();
    if (err_inst + err_addr + err_data + err_id + err_proto == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

/* verif/fetch_testdata.txt */
// words 0..15: 64-bit image at 0x80000000, {instruction at +4, instruction at +0}
// from @10: commands, bits 63:60 op (1 run n, 2 redirect addr, 3 stall n, 4 data read addr, 0 end)
00200113_00100093
00400213_00300193
00600313_00500293
00800413_00700393
00a00513_00900493
00c00613_00b00593
00e00713_00d00693
01000813_00f00793
01200913_01100893
01400a13_01300993
01600b13_01500a93
01800c13_01700b93
01a00d13_01900c93
01c00e13_01b00d93
01e00f13_01d00e93
002080b3_01f00f93
@10
1000000000000003
1000000000000003
2000000080000040
1000000000000003
3000000000000014
1000000000000002
4000000080000018
1000000000000003
400000008000004c
1000000000000002
2000000080000004
1000000000000003
3000000000000008
1000000000000003
0000000000000000

/* filelist.f */
+incdir+verilog
verilog/fetch_pkg.sv
verilog/pc_gen.sv
verilog/req_arbiter.sv
verilog/axi_rd_master.sv
verilog/resp_router.sv
verilog/fetch_unit_top.sv
verif/tb_clk_gen.sv
verif/tb_axi_mem.sv
verif/tb_fetch_unit.sv

/* Bender.yml */
package:
  name: fetch_unit

export_include_dirs:
  - verilog

sources:
  - verilog/fetch_pkg.sv
  - verilog/pc_gen.sv
  - verilog/req_arbiter.sv
  - verilog/axi_rd_master.sv
  - verilog/resp_router.sv
  - verilog/fetch_unit_top.sv
  - target: verif
    files:
      - verif/tb_clk_gen.sv
      - verif/tb_axi_mem.sv
      - verif/tb_fetch_unit.sv
